//--- cpuTop.f
logic/cpuPkg.sv
logic/ctrlIf.sv
logic/control.sv
logic/seqFsm.sv
logic/pcCounter.sv
logic/regFile.sv
logic/alu.sv
logic/cpuTop.sv
dv/cpuChecker.sv
dv/cpuTb.sv

//--- dv/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker (
        input  logic         clk,
        input  logic         instrValid,
        input  logic         fetchReq,
        input  logic [15:0]  pc,
        input  logic         wbValid,
        input  logic [2:0]   wbReg,
        input  logic [15:0]  wbData,
        input  logic         halted,
        input  logic         err,
        input  logic         testStart,
        input  logic         testEnd,
        input  logic         allDone,
        input  logic [127:0] testName,
        input  logic [2:0]   expReg [64],
        input  logic [15:0]  expVal [64],
        input  int           expCount,
        input  logic         expErr,
        output int           errCount
);

        int   wbIdx = 0;
        int   testErrs = 0;
        int   testsPassed = 0;
        int   testsFailed = 0;
        logic validPrev = 1'b0;
        logic fetchSeen = 1'b0;

        initial errCount = 0;

        task automatic flagError(input string msg);
                $display("%s", msg);
                testErrs++;
                errCount++;
        endtask

        task automatic reportMismatch(input string sigName, input int expected, input int got);
                $display("Mismatch at %0t: %s expected %0h got %0h",
                         $time, sigName, expected, got);
                testErrs++;
                errCount++;
        endtask

        // Outputs are stable by the falling edge
        always @(negedge clk) begin
                if (testStart) begin
                        wbIdx     = 0;
                        testErrs  = 0;
                        fetchSeen = 1'b0;
                end else if (testEnd) begin
                        if (wbIdx < expCount)
                                flagError($sformatf("Test %0s is missing %0d write-backs",
                                                    testName, expCount - wbIdx));
                        if (err !== expErr)
                                reportMismatch("err", expErr, err);
                        if (testErrs == 0) begin
                                $display("Test %0s: passed", testName);
                                testsPassed++;
                        end else begin
                                $display("Test %0s: failed with %0d errors", testName, testErrs);
                                testsFailed++;
                        end
                end else if (allDone) begin
                        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                                 testsPassed + testsFailed, testsPassed, testsFailed, errCount);
                end

                if (wbValid) begin
                        if (!validPrev)
                                flagError($sformatf(
                                        "At %0t a write-back had no instruction one cycle before",
                                        $time));
                        if (wbIdx >= expCount) begin
                                flagError($sformatf("At %0t an extra write-back to R%0d arrived",
                                                    $time, wbReg));
                        end else begin
                                if (wbReg !== expReg[wbIdx])
                                        reportMismatch("wbReg", expReg[wbIdx], wbReg);
                                if (wbData !== expVal[wbIdx])
                                        reportMismatch("wbData", expVal[wbIdx], wbData);
                                wbIdx++;
                        end
                end

                if (fetchReq) begin
                        if (halted)
                                flagError($sformatf("At %0t the core fetched after stopping",
                                                    $time));
                        if (!fetchSeen && pc !== 16'h0000)
                                reportMismatch("pc", 0, pc);    // First fetch after reset
                        if (pc[0] !== 1'b0)
                                flagError($sformatf("At %0t a fetch used odd address %0h",
                                                    $time, pc));
                        fetchSeen = 1'b1;
                end

                validPrev = instrValid;
        end

endmodule

//--- dv/cpuStim.txt
# T name | P byte address, instruction word (hex) | W register, value (hex) | E expected err
T immAlu
P 00 C112
P 02 415D
P 04 4965
P 06 519F
P 08 59A3
P 0A A3C4
P 0C A9E3
P 0E B104
P 10 BB48
P 12 0000
W 1 0012
W 2 000F
W 3 FFF3
W 4 000D
W 5 0010
W 6 FF3F
W 7 0090
W 0 2001
W 2 00FF
E 0
T rFormat
P 00 C185
P 02 C203
P 04 9240
P 06 D94C
P 08 D951
P 0A D956
P 0C D95B
P 0E D19F
P 10 D182
P 12 E94C
P 14 F230
P 16 F954
P 18 E138
P 1A 0000
W 1 FF85
W 2 0003
W 2 0340
W 3 02C5
W 4 03BB
W 5 FCC5
W 6 FC85
W 7 001F
W 0 F0BF
W 3 0001
W 4 0000
W 5 0001
W 6 0001
E 0
T branches
P 00 C100
P 02 6102
P 04 C211
P 06 6902
P 08 C322
P 0A C480
P 0C 7402
P 0E C233
P 10 7C02
P 12 2002
P 14 C244
P 16 C555
P 18 0000
W 1 0000
W 3 0022
W 4 FF80
W 5 0055
E 0
T jumps
P 00 3004
P 02 C111
P 04 0000
P 06 C210
P 08 2A02
P 0A C333
P 12 3A08
P 14 C344
P 18 C466
P 1A 0000
W 7 0002
W 2 0010
W 7 0014
W 4 0066
E 0
T badOpcode
P 00 C101
P 02 8000
P 04 C202
W 1 0001
E 1

//--- dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

        localparam int MemWords = 256;
        localparam int MaxWb    = 64;

        logic        clk = 1'b0;
        logic        rstN;
        logic [15:0] instr;
        logic        instrValid;
        logic        fetchReq;
        logic [15:0] pc;
        logic        wbValid;
        logic [2:0]  wbReg;
        logic [15:0] wbData;
        logic        halted;
        logic        err;

        logic [15:0]  mem [MemWords];
        logic [2:0]   expReg [MaxWb];
        logic [15:0]  expVal [MaxWb];
        int           expCount = 0;
        logic         expErr;
        logic [127:0] testName;
        logic         testStart;
        logic         testEnd;
        logic         allDone;
        int           errCount;

        int unsigned lcgState = 5778;
        int          cycles = 0;
        int          cycleLimit = 200;
        logic        pending = 1'b0;
        logic [15:0] fetchAddr;
        int          delay;

        cpuTop u_dut (
                .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid),
                .fetchReq(fetchReq), .pc(pc), .wbValid(wbValid), .wbReg(wbReg),
                .wbData(wbData), .halted(halted), .err(err)
        );

        cpuChecker uChecker (
                .clk(clk), .instrValid(instrValid), .fetchReq(fetchReq), .pc(pc),
                .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err),
                .testStart(testStart), .testEnd(testEnd), .allDone(allDone),
                .testName(testName), .expReg(expReg), .expVal(expVal),
                .expCount(expCount), .expErr(expErr), .errCount(errCount)
        );

        always #20 clk = ~clk;

        function automatic int unsigned lcgNext(input int unsigned s);
                return s * 32'd1103515245 + 32'd12345;
        endfunction

        // Capture a fetch request and draw its answer delay
        always @(negedge clk) begin
                if (rstN && fetchReq && !pending) begin
                        pending   = 1'b1;
                        fetchAddr = pc;
                        lcgState  = lcgNext(lcgState);
                        delay     = int'((lcgState >> 16) % 4);
                end
        end

        always @(posedge clk) begin
                if (!rstN) begin
                        instrValid <= 1'b0;
                        pending = 1'b0;
                end else if (pending && delay == 0) begin
                        instr      <= mem[fetchAddr[8:1]];
                        instrValid <= 1'b1;
                        pending = 1'b0;
                end else begin
                        instrValid <= 1'b0;
                        if (pending)
                                delay--;
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles > cycleLimit) begin
                        $display("Timeout: the run took more than %0d cycles", cycleLimit);
                        $display("Finished with errors");
                        $finish;
                end
        end

        // Unused words decode as a memory op and raise err
        task automatic fillMem();
                for (int i = 0; i < MemWords; i++)
                        mem[i] = 16'h8000 | 16'(i);
        endtask

        task automatic runTest();
                @(posedge clk);
                rstN      <= 1'b0;
                testStart <= 1'b1;
                @(posedge clk);
                testStart <= 1'b0;
                repeat (15) @(posedge clk);
                rstN <= 1'b1;
                @(negedge clk);
                while (!halted)
                        @(negedge clk);
                repeat (4) @(posedge clk);      // Room for a stray write-back
                testEnd <= 1'b1;
                @(posedge clk);
                testEnd <= 1'b0;
        endtask

        initial begin
                int    fd;
                int    n;
                int    a;
                int    b;
                int    pWords;
                string line;

                rstN       = 1'b0;
                instr      = '0;
                instrValid = 1'b0;
                testStart  = 1'b0;
                testEnd    = 1'b0;
                allDone    = 1'b0;
                expErr     = 1'b0;
                testName   = '0;
                pWords     = 0;
                fillMem();

                fd = $fopen("dv/cpuStim.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the stimulus file dv/cpuStim.txt");
                        $display("Finished with errors");
                        $finish;
                end else begin
                        while (!$feof(fd)) begin
                                n = $fgets(line, fd);
                                if (n > 0 && line[0] == "P")
                                        pWords++;
                        end
                        $fclose(fd);
                        cycleLimit = pWords * 4 * 8 + 200;

                        fd = $fopen("dv/cpuStim.txt", "r");
                        while (!$feof(fd)) begin
                                line = "";
                                n = $fgets(line, fd);
                                if (n > 0) begin
                                        case (line[0])
                                                "T": begin
                                                        n = $sscanf(line, "T %s", testName);
                                                        fillMem();
                                                        expCount = 0;
                                                end
                                                "P": begin
                                                        n = $sscanf(line, "P %h %h", a, b);
                                                        mem[a[8:1]] = b[15:0];
                                                end
                                                "W": begin
                                                        n = $sscanf(line, "W %h %h", a, b);
                                                        expReg[expCount] = a[2:0];
                                                        expVal[expCount] = b[15:0];
                                                        expCount++;
                                                end
                                                "E": begin
                                                        n = $sscanf(line, "E %h", a);
                                                        expErr = a[0];
                                                        runTest();
                                                end
                                                default: ;
                                        endcase
                                end
                        end
                        $fclose(fd);

                        @(posedge clk);
                        allDone <= 1'b1;
                        @(posedge clk);
                        allDone <= 1'b0;
                        @(negedge clk);
                        if (errCount == 0)
                                $display("Finished with no errors");
                        else
                                $display("Finished with errors");
                        $finish;
                end
        end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
        ctrlIf.dp                             ctrl,
        input  logic [15:0]                   instr,
        input  logic [cpuPkg::DataWidth-1:0] rsVal,
        input  logic [cpuPkg::DataWidth-1:0] rtVal,
        output logic [cpuPkg::DataWidth-1:0] result
);

        localparam int W = cpuPkg::DataWidth;

        logic [W-1:0]   imm5Ext;
        logic [W-1:0]   imm8Ext;
        logic [W-1:0]   bOp;
        logic [W-1:0]   a;
        logic [W-1:0]   b;
        logic [W:0]     sum;
        logic [2*W-1:0] rolWide;
        logic [2*W-1:0] rorWide;

        assign imm5Ext = ctrl.zeroExt ? {{(W-5){1'b0}}, instr[4:0]} :
                                        {{(W-5){instr[4]}}, instr[4:0]};
        assign imm8Ext = {{(W-8){instr[7]}}, instr[7:0]};

        always_comb begin
                case (ctrl.bSrc)
                        cpuPkg::BSrcImm5: bOp = imm5Ext;
                        cpuPkg::BSrcImm8: bOp = imm8Ext;
                        default:          bOp = rtVal;
                endcase
        end

        assign a       = ctrl.invA ? ~rsVal : rsVal;
        assign b       = ctrl.invB ? ~bOp : bOp;
        assign sum     = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, ctrl.cin};
        assign rolWide = {a, a} << b[3:0];
        assign rorWide = {a, a} >> b[3:0];

        always_comb begin
                case (ctrl.aluOpr)
                        cpuPkg::AluAdd:   result = sum[W-1:0];
                        cpuPkg::AluXor:   result = a ^ b;
                        cpuPkg::AluAndn:  result = a & b;       // B already inverted
                        cpuPkg::AluRol:   result = rolWide[2*W-1:W];
                        cpuPkg::AluSll:   result = a << b[3:0];
                        cpuPkg::AluRor:   result = rorWide[W-1:0];
                        cpuPkg::AluSrl:   result = a >> b[3:0];
                        cpuPkg::AluSeq:   result = {{(W-1){1'b0}}, a == b};
                        cpuPkg::AluSlt:   result = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
                        cpuPkg::AluSle:   result = {{(W-1){1'b0}}, $signed(a) <= $signed(b)};
                        cpuPkg::AluSco:   result = {{(W-1){1'b0}}, sum[W]};
                        cpuPkg::AluPassB: result = b;
                        cpuPkg::AluSlbi:  result = {a[W-9:0], b[7:0]};
                        default:          result = '0;
                endcase
        end

endmodule

//--- logic/control.sv
`timescale 1ns/1ps

module control (
        input  logic [15:0] instr,
        ctrlIf.dec          ctrl
);

        logic [4:0] op;
        logic [1:0] funct;

        assign op    = instr[15:11];
        assign funct = instr[1:0];

        always_comb begin
                ctrl.regWrt  = 1'b0;
                ctrl.regDst  = cpuPkg::DstRd;
                ctrl.regSrc  = cpuPkg::SrcAlu;
                ctrl.bSrc    = cpuPkg::BSrcReg;
                ctrl.zeroExt = 1'b0;
                ctrl.invA    = 1'b0;
                ctrl.invB    = 1'b0;
                ctrl.cin     = 1'b0;
                ctrl.aluOpr  = cpuPkg::AluAdd;
                ctrl.aluJmp  = 1'b0;
                ctrl.brMode  = cpuPkg::BrNone;
                ctrl.halt    = 1'b0;
                ctrl.err     = 1'b0;

                case (op)
                        cpuPkg::OpHalt: ctrl.halt = 1'b1;
                        cpuPkg::OpNop: ;                  // Nothing changes

                        cpuPkg::OpAddi, cpuPkg::OpSubi: begin
                                ctrl.regWrt = 1'b1;
                                ctrl.bSrc   = cpuPkg::BSrcImm5;
                                ctrl.invA   = (op == cpuPkg::OpSubi);  // Imm minus Rs
                                ctrl.cin    = (op == cpuPkg::OpSubi);
                        end
                        cpuPkg::OpXori, cpuPkg::OpAndni: begin
                                ctrl.regWrt  = 1'b1;
                                ctrl.bSrc    = cpuPkg::BSrcImm5;
                                ctrl.zeroExt = 1'b1;
                                ctrl.invB    = (op == cpuPkg::OpAndni);
                                ctrl.aluOpr  = (op == cpuPkg::OpAndni) ?
                                               cpuPkg::AluAndn : cpuPkg::AluXor;
                        end
                        cpuPkg::OpRoli, cpuPkg::OpSlli, cpuPkg::OpRori, cpuPkg::OpSrli: begin
                                ctrl.regWrt  = 1'b1;
                                ctrl.bSrc    = cpuPkg::BSrcImm5;
                                ctrl.zeroExt = 1'b1;
                                case (op[1:0])
                                        2'b00:   ctrl.aluOpr = cpuPkg::AluRol;
                                        2'b01:   ctrl.aluOpr = cpuPkg::AluSll;
                                        2'b10:   ctrl.aluOpr = cpuPkg::AluRor;
                                        default: ctrl.aluOpr = cpuPkg::AluSrl;
                                endcase
                        end

                        cpuPkg::OpAluR: begin
                                ctrl.regWrt = 1'b1;
                                case (funct)
                                        2'b00: ctrl.aluOpr = cpuPkg::AluAdd;
                                        2'b01: begin        // Rt minus Rs
                                                ctrl.invA = 1'b1;
                                                ctrl.cin  = 1'b1;
                                        end
                                        2'b10: ctrl.aluOpr = cpuPkg::AluXor;
                                        default: begin
                                                ctrl.invB   = 1'b1;
                                                ctrl.aluOpr = cpuPkg::AluAndn;
                                        end
                                endcase
                        end
                        cpuPkg::OpShiftR: begin
                                ctrl.regWrt = 1'b1;
                                case (funct)
                                        2'b00:   ctrl.aluOpr = cpuPkg::AluRol;
                                        2'b01:   ctrl.aluOpr = cpuPkg::AluSll;
                                        2'b10:   ctrl.aluOpr = cpuPkg::AluRor;
                                        default: ctrl.aluOpr = cpuPkg::AluSrl;
                                endcase
                        end
                        cpuPkg::OpSeq, cpuPkg::OpSlt, cpuPkg::OpSle, cpuPkg::OpSco: begin
                                ctrl.regWrt = 1'b1;
                                case (op[1:0])
                                        2'b00:   ctrl.aluOpr = cpuPkg::AluSeq;
                                        2'b01:   ctrl.aluOpr = cpuPkg::AluSlt;
                                        2'b10:   ctrl.aluOpr = cpuPkg::AluSle;
                                        default: ctrl.aluOpr = cpuPkg::AluSco;
                                endcase
                        end

                        cpuPkg::OpBeqz: ctrl.brMode = cpuPkg::BrEqz;
                        cpuPkg::OpBnez: ctrl.brMode = cpuPkg::BrNez;
                        cpuPkg::OpBltz: ctrl.brMode = cpuPkg::BrLtz;
                        cpuPkg::OpBgez: ctrl.brMode = cpuPkg::BrGez;

                        cpuPkg::OpLbi, cpuPkg::OpSlbi: begin
                                ctrl.regWrt = 1'b1;
                                ctrl.regDst = cpuPkg::DstRs;
                                ctrl.bSrc   = cpuPkg::BSrcImm8;
                                ctrl.aluOpr = (op == cpuPkg::OpLbi) ?
                                              cpuPkg::AluPassB : cpuPkg::AluSlbi;
                        end

                        cpuPkg::OpJ, cpuPkg::OpJr, cpuPkg::OpJal, cpuPkg::OpJalr: begin
                                ctrl.brMode = cpuPkg::BrJump;
                                ctrl.aluJmp = op[0];        // JR and JALR
                                if (op[1]) begin            // Link into R7
                                        ctrl.regWrt = 1'b1;
                                        ctrl.regDst = cpuPkg::DstR7;
                                        ctrl.regSrc = cpuPkg::SrcPcNext;
                                end
                        end

                        default: ctrl.err = 1'b1;   // Includes memory and exception ops
                endcase
        end

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

        localparam int DataWidth    = 16;
        localparam int RegCount     = 8;
        localparam int RegAddrWidth = 3;

        // Opcode field, instr[15:11]
        localparam logic [4:0] OpHalt   = 5'b00000;
        localparam logic [4:0] OpNop    = 5'b00001;
        localparam logic [4:0] OpJ      = 5'b00100;
        localparam logic [4:0] OpJr     = 5'b00101;
        localparam logic [4:0] OpJal    = 5'b00110;
        localparam logic [4:0] OpJalr   = 5'b00111;
        localparam logic [4:0] OpAddi   = 5'b01000;
        localparam logic [4:0] OpSubi   = 5'b01001;
        localparam logic [4:0] OpXori   = 5'b01010;
        localparam logic [4:0] OpAndni  = 5'b01011;
        localparam logic [4:0] OpBeqz   = 5'b01100;
        localparam logic [4:0] OpBnez   = 5'b01101;
        localparam logic [4:0] OpBltz   = 5'b01110;
        localparam logic [4:0] OpBgez   = 5'b01111;
        localparam logic [4:0] OpSlbi   = 5'b10010;
        localparam logic [4:0] OpRoli   = 5'b10100;
        localparam logic [4:0] OpSlli   = 5'b10101;
        localparam logic [4:0] OpRori   = 5'b10110;
        localparam logic [4:0] OpSrli   = 5'b10111;
        localparam logic [4:0] OpLbi    = 5'b11000;
        localparam logic [4:0] OpShiftR = 5'b11010;  // ROL SLL ROR SRL by funct
        localparam logic [4:0] OpAluR   = 5'b11011;  // ADD SUB XOR ANDN by funct
        localparam logic [4:0] OpSeq    = 5'b11100;
        localparam logic [4:0] OpSlt    = 5'b11101;
        localparam logic [4:0] OpSle    = 5'b11110;
        localparam logic [4:0] OpSco    = 5'b11111;

        localparam logic [3:0] AluAdd   = 4'd0;
        localparam logic [3:0] AluXor   = 4'd1;
        localparam logic [3:0] AluAndn  = 4'd2;
        localparam logic [3:0] AluRol   = 4'd3;
        localparam logic [3:0] AluSll   = 4'd4;
        localparam logic [3:0] AluRor   = 4'd5;
        localparam logic [3:0] AluSrl   = 4'd6;
        localparam logic [3:0] AluSeq   = 4'd7;
        localparam logic [3:0] AluSlt   = 4'd8;
        localparam logic [3:0] AluSle   = 4'd9;
        localparam logic [3:0] AluSco   = 4'd10;
        localparam logic [3:0] AluPassB = 4'd11;
        localparam logic [3:0] AluSlbi  = 4'd12;

        localparam logic       SrcAlu    = 1'b0;
        localparam logic       SrcPcNext = 1'b1;

        localparam logic [1:0] BSrcReg  = 2'd0;
        localparam logic [1:0] BSrcImm5 = 2'd1;
        localparam logic [1:0] BSrcImm8 = 2'd2;

        localparam logic [1:0] DstRd = 2'd0;
        localparam logic [1:0] DstRs = 2'd1;
        localparam logic [1:0] DstR7 = 2'd2;

        localparam logic [2:0] BrNone = 3'd0;
        localparam logic [2:0] BrEqz  = 3'd1;
        localparam logic [2:0] BrNez  = 3'd2;
        localparam logic [2:0] BrLtz  = 3'd3;
        localparam logic [2:0] BrGez  = 3'd4;
        localparam logic [2:0] BrJump = 3'd5;

endpackage

//--- logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
        input  logic        clk,
        input  logic        rstN,
        input  logic [15:0] instr,
        input  logic        instrValid,
        output logic        fetchReq,
        output logic [15:0] pc,
        output logic        wbValid,
        output logic [2:0]  wbReg,
        output logic [15:0] wbData,
        output logic        halted,
        output logic        err
);

        ctrlIf ctrl ();

        logic [15:0] instrReg;
        logic [15:0] rsVal;
        logic [15:0] rtVal;
        logic [15:0] aluResult;
        logic [15:0] pcNext;
        logic        loadInstr;
        logic        execEn;

        always_ff @(posedge clk) begin
                if (loadInstr)
                        instrReg <= instr;
        end

        always_comb begin
                case (ctrl.regDst)
                        cpuPkg::DstRs: wbReg = instrReg[10:8];
                        cpuPkg::DstR7: wbReg = cpuPkg::RegAddrWidth'(cpuPkg::RegCount - 1);
                        default:       wbReg = (instrReg[15:14] == 2'b11) ? instrReg[4:2] :
                                                                             instrReg[7:5];
                endcase
        end
        // R-format opcodes all start 11 and keep Rd in bits 4:2

        assign wbData  = (ctrl.regSrc == cpuPkg::SrcPcNext) ? pcNext : aluResult;
        assign wbValid = execEn & ctrl.regWrt;

        control uControl (.instr(instrReg), .ctrl(ctrl));

        seqFsm uSeq (
                .clk(clk), .rstN(rstN), .instrValid(instrValid), .ctrl(ctrl),
                .fetchReq(fetchReq), .loadInstr(loadInstr), .execEn(execEn),
                .halted(halted), .err(err)
        );

        pcCounter uPc (
                .clk(clk), .rstN(rstN), .execEn(execEn), .ctrl(ctrl),
                .rsVal(rsVal), .instr(instrReg), .pc(pc), .pcNext(pcNext)
        );

        regFile uRegs (
                .clk(clk), .rstN(rstN), .wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData),
                .rdAddrA(instrReg[10:8]), .rdAddrB(instrReg[7:5]), .rdA(rsVal), .rdB(rtVal)
        );

        alu uAlu (
                .ctrl(ctrl), .instr(instrReg), .rsVal(rsVal), .rtVal(rtVal),
                .result(aluResult)
        );

endmodule

//--- logic/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;

        logic       regWrt;
        logic [1:0] regDst;
        logic       regSrc;
        logic [1:0] bSrc;     // Register, imm5 or imm8
        logic       zeroExt;
        logic       invA;
        logic       invB;
        logic       cin;
        logic [3:0] aluOpr;
        logic       aluJmp;   // Target from Rs, not from PC
        logic [2:0] brMode;
        logic       halt;
        logic       err;

        modport dec (
                output regWrt, regDst, regSrc, bSrc, zeroExt, invA, invB, cin,
                output aluOpr, aluJmp, brMode, halt, err
        );

        modport dp (
                input regWrt, regDst, regSrc, bSrc, zeroExt, invA, invB, cin,
                input aluOpr, aluJmp, brMode, halt, err
        );

endinterface

//--- logic/pcCounter.sv
`timescale 1ns/1ps

module pcCounter (
        input  logic                          clk,
        input  logic                          rstN,
        input  logic                          execEn,
        ctrlIf.dp                             ctrl,
        input  logic [cpuPkg::DataWidth-1:0] rsVal,
        input  logic [15:0]                   instr,
        output logic [cpuPkg::DataWidth-1:0] pc,
        output logic [cpuPkg::DataWidth-1:0] pcNext
);

        logic [cpuPkg::DataWidth-1:0] imm8Ext;
        logic [cpuPkg::DataWidth-1:0] disp11Ext;
        logic [cpuPkg::DataWidth-1:0] target;
        logic                         taken;

        assign pcNext    = pc + cpuPkg::DataWidth'(2);
        assign imm8Ext   = {{(cpuPkg::DataWidth-8){instr[7]}}, instr[7:0]};
        assign disp11Ext = {{(cpuPkg::DataWidth-11){instr[10]}}, instr[10:0]};

        always_comb begin
                case (ctrl.brMode)
                        cpuPkg::BrEqz:  taken = (rsVal == '0);
                        cpuPkg::BrNez:  taken = (rsVal != '0);
                        cpuPkg::BrLtz:  taken = rsVal[cpuPkg::DataWidth-1];
                        cpuPkg::BrGez:  taken = ~rsVal[cpuPkg::DataWidth-1];
                        cpuPkg::BrJump: taken = 1'b1;
                        default:        taken = 1'b0;
                endcase
        end

        always_comb begin
                if (ctrl.aluJmp)
                        target = rsVal + imm8Ext;           // JR, JALR
                else if (ctrl.brMode == cpuPkg::BrJump)
                        target = pcNext + disp11Ext;        // J, JAL
                else
                        target = pcNext + imm8Ext;
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN)
                        pc <= '0;
                else if (execEn)
                        pc <= taken ? target : pcNext;
        end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
        input  logic                             clk,
        input  logic                             rstN,
        input  logic                             wrEn,
        input  logic [cpuPkg::RegAddrWidth-1:0] wrAddr,
        input  logic [cpuPkg::DataWidth-1:0]    wrData,
        input  logic [cpuPkg::RegAddrWidth-1:0] rdAddrA,
        input  logic [cpuPkg::RegAddrWidth-1:0] rdAddrB,
        output logic [cpuPkg::DataWidth-1:0]    rdA,
        output logic [cpuPkg::DataWidth-1:0]    rdB
);

        logic [cpuPkg::DataWidth-1:0] regs [cpuPkg::RegCount];

        assign rdA = regs[rdAddrA];
        assign rdB = regs[rdAddrB];

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < cpuPkg::RegCount; i++)
                                regs[i] <= '0;
                end else if (wrEn) begin
                        regs[wrAddr] <= wrData;     // R0 writes like any other
                end
        end

endmodule

//--- logic/seqFsm.sv
`timescale 1ns/1ps

module seqFsm (
        input  logic clk,
        input  logic rstN,
        input  logic instrValid,
        ctrlIf.dp    ctrl,
        output logic fetchReq,
        output logic loadInstr,
        output logic execEn,
        output logic halted,
        output logic err
);

        typedef enum logic [1:0] {StFetch, StWait, StExec, StStop} stateT;

        stateT state;
        stateT stateNext;
        logic  stop;

        assign stop      = ctrl.halt | ctrl.err;
        assign loadInstr = (state == StWait) & instrValid;
        assign execEn    = (state == StExec);

        always_comb begin
                stateNext = state;
                case (state)
                        StFetch: if (fetchReq) stateNext = StWait;  // Extra cycle after reset
                        StWait:  if (instrValid) stateNext = StExec;
                        StExec:  stateNext = stop ? StStop : StFetch;
                        default: stateNext = StStop;
                endcase
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        state    <= StFetch;
                        fetchReq <= 1'b0;
                        halted   <= 1'b0;
                        err      <= 1'b0;
                end else begin
                        state    <= stateNext;
                        fetchReq <= (stateNext == StFetch);
                        if (execEn && stop)
                                halted <= 1'b1;     // Sticky until reset
                        if (execEn && ctrl.err)
                                err <= 1'b1;
                end
        end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f cpuTop.f --top-module cpuTb -o cpuSim \
        && ./obj_dir/cpuSim | tee /dev/stderr | grep -q "Finished with no errors" \
        && echo "Simulation passed" \
        || { echo "Simulation failed"; exit 1; }
